//--- src.f
snake_pkg.sv
snake_if.sv
snake_body.sv
snake_collide.sv
snake_game_ctrl.sv
snake_top.sv
snake_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the snake core testbench with Verilator
# The exit status of the simulation is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module snake_tb -f src.f -o snake_sim &&
./obj_dir/snake_sim &&
echo "simulation run completed" ||
{ echo "simulation run failed"; exit 1; }

//--- snake_tb.sv
`timescale 1ns/10ps
`default_nettype none

module snake_tb;
    import snake_pkg::*;

    localparam int MAX_LEN   = 8;
    localparam int GRID_W    = 32;
    localparam int GRID_H    = 24;
    localparam int CYCLE_LIM = 20000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Reference model of the game
    int          m_x [MAX_LEN];
    int          m_y [MAX_LEN];
    int          m_len;
    int          m_score;
    game_state_t m_state;
    dir_t        m_dir;
    int          m_food_x;
    int          m_food_y;
    logic [47:0] exp_vec;

    // Handed to the compare process
    string       chk_name;
    logic [31:0] chk_exp;
    logic [31:0] chk_got;
    event        chk_ev;

    integer      seed;
    int          cycles = 0;
    logic [31:0] r;
    int          nx;
    int          ny;

    snake_top DUT (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIM) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIM);
            $display("Result: FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    always @(chk_ev) begin
        assert (chk_got === chk_exp) else begin
            $display("[ERROR] %s expected %h actual %h", chk_name, chk_exp, chk_got);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [47:0] model_pack();
        logic [15:0] head;
        logic [15:0] status;
        head   = {8'(m_y[0]), 8'(m_x[0])};
        status = {8'(m_len), 6'b0, m_state};
        return {16'(m_score), status, head};
    endfunction

    function automatic void model_restart();
        for (int i = 0; i < MAX_LEN; i++) begin
            m_x[i] = 0;
            m_y[i] = 0;
        end
        m_x[0]  = START_X;
        m_y[0]  = START_Y;
        m_len   = 1;
        m_score = 0;
        m_dir   = RIGHT;
    endfunction

    // Cell one step ahead of the head, may be off the board
    function automatic void next_cell(output int cx, output int cy);
        cx = m_x[0];
        cy = m_y[0];
        case (m_dir)
            RIGHT: cx = cx + 1;
            DOWN:  cy = cy - 1;
            LEFT:  cx = cx - 1;
            UP:    cy = cy + 1;
        endcase
    endfunction

    function automatic logic [47:0] model_step(input logic [31:0] ctrl);
        int cx;
        int cy;
        bit wall;
        bit eat;
        bit tail_out;
        bit self_hit;
        if (ctrl[0]) begin
            model_restart();
            m_state = RUN;
        end else if (ctrl[1] && (m_state == RUN)) begin
            next_cell(cx, cy);
            wall     = (cx < 0) || (cx >= GRID_W) || (cy < 0) || (cy >= GRID_H);
            eat      = !wall && (cx == m_food_x) && (cy == m_food_y);
            tail_out = !(eat && (m_len < MAX_LEN));
            self_hit = 1'b0;
            for (int i = 0; i < m_len; i++) begin
                if ((m_x[i] == cx) && (m_y[i] == cy) && !(tail_out && (i == m_len - 1))) begin
                    self_hit = 1'b1;
                end
            end
            if (wall || self_hit) begin
                m_state = DEAD;
            end else begin
                if (eat) begin
                    m_score = m_score + 1;
                end
                if (eat && (m_len < MAX_LEN)) begin
                    m_len = m_len + 1;
                end
                for (int i = MAX_LEN - 1; i > 0; i--) begin
                    m_x[i] = m_x[i-1];
                    m_y[i] = m_y[i-1];
                end
                m_x[0] = cx;
                m_y[0] = cy;
            end
        end
        return model_pack();
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // APB driver and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_access(input logic wr, input logic [2:0] idx, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err, output logic rdy);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = {idx, 2'b00};
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        // Access phase outputs are settled well before the edge
        #10;
        rdata = prdata;
        err   = pslverr;
        rdy   = pready;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        chk_name = name;
        chk_exp  = exp;
        chk_got  = got;
        -> chk_ev;
        #1;
    endtask

    task automatic read_check(input string name, input reg_addr_t idx, input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        logic        rdy;
        apb_access(1'b0, idx, 32'h0, rdata, err, rdy);
        compare("pready", 32'h1, {31'b0, rdy});
        compare("pslverr", 32'h0, {31'b0, err});
        compare(name, exp, rdata);
    endtask

    task automatic write_reg(input reg_addr_t idx, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        logic        rdy;
        apb_access(1'b1, idx, data, rdata, err, rdy);
        compare("pslverr", 32'h0, {31'b0, err});
        case (idx)
            REG_CTRL: exp_vec = model_step(data);
            REG_DIR:  m_dir = dir_t'(data[1:0]);
            REG_FOOD: begin
                m_food_x = int'(data[7:0]);
                m_food_y = int'(data[15:8]);
            end
            default:  m_dir = m_dir;
        endcase
    endtask

    task automatic check_state();
        read_check("HEAD", REG_HEAD, {16'b0, exp_vec[15:0]});
        read_check("STATUS", REG_STATUS, {16'b0, exp_vec[31:16]});
        read_check("SCORE", REG_SCORE, {16'b0, exp_vec[47:32]});
    endtask

    // Bad index or read-only write must error out and leave everything alone
    task automatic bad_access(input logic wr, input logic [2:0] idx);
        logic [31:0] rdata;
        logic        err;
        logic        rdy;
        apb_access(wr, idx, 32'hffff_ffff, rdata, err, rdy);
        compare("pslverr", 32'h1, {31'b0, err});
        check_state();
        read_check("DIR", REG_DIR, {30'b0, m_dir});
        read_check("FOOD", REG_FOOD, {16'b0, 8'(m_food_y), 8'(m_food_x)});
    endtask

    task automatic step_and_check();
        write_reg(REG_CTRL, 32'h2);
        check_state();
    endtask

    // Food on the next cell, then one move
    task automatic feed_and_step();
        next_cell(nx, ny);
        write_reg(REG_FOOD, {16'b0, 8'(ny), 8'(nx)});
        step_and_check();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Scenarios
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 32'hc0fc22e8;
        model_restart();
        m_state  = IDLE;
        m_food_x = 0;
        m_food_y = 0;
        exp_vec  = model_pack();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle after reset, steps ignored
        check_state();
        step_and_check();

        // One lap through all four directions
        write_reg(REG_CTRL, 32'h1);
        check_state();
        for (int d = 3; d < 7; d++) begin
            write_reg(REG_DIR, 32'(d % 4));
            read_check("DIR", REG_DIR, {30'b0, m_dir});
            step_and_check();
            step_and_check();
        end

        // Ten meals, length saturates at MAX_LEN
        write_reg(REG_DIR, 32'(RIGHT));
        repeat (10) feed_and_step();

        // Up into the top wall, then dead steps and a restart
        write_reg(REG_DIR, 32'(UP));
        for (int k = 0; (k < 40) && (m_state == RUN); k++) begin
            step_and_check();
        end
        step_and_check();
        write_reg(REG_CTRL, 32'h3);
        check_state();

        // Reversal into the body
        repeat (3) feed_and_step();
        write_reg(REG_DIR, 32'(LEFT));
        step_and_check();

        // Square turn that ends on the cell the tail is leaving
        write_reg(REG_CTRL, 32'h1);
        repeat (3) feed_and_step();
        write_reg(REG_FOOD, {16'b0, 8'd20, 8'd30});
        for (int d = 0; d < 3; d++) begin
            write_reg(REG_DIR, (d == 0) ? 32'(UP) : (d == 1) ? 32'(LEFT) : 32'(DOWN));
            step_and_check();
        end

        bad_access(1'b0, 3'd6);
        bad_access(1'b1, 3'd6);
        bad_access(1'b1, 3'd3);

        // Random walk
        for (int n = 0; n < 300; n++) begin
            if (m_state != RUN) begin
                write_reg(REG_CTRL, 32'h1);
            end
            r = $random(seed);
            if (r[3:2] == 2'b00) begin
                write_reg(REG_DIR, {30'b0, r[1:0]});
            end
            if (r[6:4] == 3'b000) begin
                next_cell(nx, ny);
                write_reg(REG_FOOD, {16'b0, 8'(ny), 8'(nx)});
            end else if (r[6:4] == 3'b001) begin
                write_reg(REG_FOOD, {16'b0, 8'(r[23:16] % GRID_H), 8'(r[15:8] % GRID_W)});
            end
            // STATUS is only an error when written
            if (r[29:27] == 3'b000) begin
                bad_access(r[30] || r[31], r[31] ? 3'd3 : 3'd6);
            end
            step_and_check();
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- snake_top.sv
`timescale 1ns/10ps
`default_nettype none

module snake_top #(
    parameter int MAX_LEN = 8,
    parameter int GRID_W  = 32,
    parameter int GRID_H  = 24
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import snake_pkg::*;

    // Food cell from the register file to the hit logic
    coord_t food_x;
    coord_t food_y;

    snake_if #(.MAX_LEN(MAX_LEN)) bus ();

    snake_game_ctrl #(
        .MAX_LEN (MAX_LEN)
    ) u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .bus     (bus.ctrl),
        .food_x  (food_x),
        .food_y  (food_y)
    );

    snake_body #(
        .MAX_LEN (MAX_LEN)
    ) u_body (
        .clk (clk),
        .rst (rst),
        .bus (bus.body)
    );

    snake_collide #(
        .MAX_LEN (MAX_LEN),
        .GRID_W  (GRID_W),
        .GRID_H  (GRID_H)
    ) u_collide (
        .bus    (bus.collide),
        .food_x (food_x),
        .food_y (food_y)
    );

endmodule

`default_nettype wire

//--- snake_game_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module snake_game_ctrl #(
    parameter int MAX_LEN = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [4:0]        paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    snake_if.ctrl             bus,
    output snake_pkg::coord_t food_x,
    output snake_pkg::coord_t food_y
);
    import snake_pkg::*;

    localparam int LEN_W = $clog2(MAX_LEN + 1);

    game_state_t      state;
    dir_t             dir_q;
    logic [15:0]      score;
    logic             restart_q;
    logic             step_q;
    logic             grow_q;
    logic [LEN_W-1:0] cur_len;

    reg_addr_t        reg_idx;
    logic             access;
    logic             bad_idx;
    logic             read_only;
    logic             wr_ok;

    ////////////////////////////////////////////////////////////////////////////
    // APB decode
    ////////////////////////////////////////////////////////////////////////////

    assign reg_idx   = reg_addr_t'(paddr[4:2]);
    assign access    = psel && penable;
    assign bad_idx   = (paddr[4:2] > 3'd5);
    assign read_only = (reg_idx == REG_STATUS) || (reg_idx == REG_SCORE)
                    || (reg_idx == REG_HEAD);

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && (bad_idx || (pwrite && read_only));
    assign wr_ok   = access && pwrite && !pslverr;

    ////////////////////////////////////////////////////////////////////////////
    // Registers and game FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            dir_q     <= RIGHT;
            food_x    <= '0;
            food_y    <= '0;
            score     <= '0;
            restart_q <= 1'b0;
            step_q    <= 1'b0;
            grow_q    <= 1'b0;
        end else begin
            // Commands are single cycle pulses
            restart_q <= 1'b0;
            step_q    <= 1'b0;
            grow_q    <= 1'b0;
            if (wr_ok) begin
                case (reg_idx)
                    REG_CTRL: begin
                        if (pwdata[CTRL_RESTART_BIT]) begin
                            restart_q <= 1'b1;
                            state     <= RUN;
                            score     <= '0;
                            dir_q     <= RIGHT;
                        end else if (pwdata[CTRL_STEP_BIT] && (state == RUN)) begin
                            if (bus.hit_wall || bus.hit_self) begin
                                // Game over, the body stays where it is
                                state <= DEAD;
                            end else begin
                                step_q <= 1'b1;
                                grow_q <= bus.ate;
                                if (bus.ate) begin
                                    score <= score + 16'd1;
                                end
                            end
                        end
                    end
                    REG_DIR: dir_q <= dir_t'(pwdata[1:0]);
                    REG_FOOD: begin
                        food_x <= pwdata[7:0];
                        food_y <= pwdata[15:8];
                    end
                    default: state <= state;
                endcase
            end
        end
    end

    assign bus.restart = restart_q;
    assign bus.step    = step_q;
    assign bus.grow    = grow_q;
    assign bus.dir     = dir_q;

    // Read data is combinational from the address
    assign cur_len = bus.length;

    always_comb begin
        prdata = '0;
        case (reg_idx)
            REG_DIR:    prdata[1:0]  = dir_q;
            REG_FOOD:   prdata[15:0] = {food_y, food_x};
            REG_STATUS: prdata[15:0] = {8'(cur_len), 6'b0, state};
            REG_SCORE:  prdata[15:0] = score;
            REG_HEAD:   prdata[15:0] = {bus.seg_y[0], bus.seg_x[0]};
            default:    prdata       = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_step_in_run: assert property (
        @(posedge clk) disable iff (rst) step_q |-> (state == RUN)
    ) else $error("snake_game_ctrl: step issued outside RUN");

    a_step_restart: assert property (
        @(posedge clk) disable iff (rst) !(step_q && restart_q)
    ) else $error("snake_game_ctrl: step and restart together");

endmodule

`default_nettype wire

//--- snake_collide.sv
`timescale 1ns/10ps
`default_nettype none

module snake_collide #(
    parameter int MAX_LEN = 8,
    parameter int GRID_W  = 32,
    parameter int GRID_H  = 24
) (
    snake_if.collide          bus,
    input  snake_pkg::coord_t food_x,
    input  snake_pkg::coord_t food_y
);
    import snake_pkg::*;

    localparam int               LEN_W     = $clog2(MAX_LEN + 1);
    localparam logic [LEN_W-1:0] MAX_LEN_L = LEN_W'(MAX_LEN);
    localparam logic [8:0]       GRID_W_L  = 9'(GRID_W);
    localparam logic [8:0]       GRID_H_L  = 9'(GRID_H);

    // One extra bit so that stepping left of 0 shows up as 9'h1ff
    logic [8:0] head_x;
    logic [8:0] head_y;
    logic       tail_leaves;

    // Candidate next head, one cell from the present head
    always_comb begin
        head_x = {1'b0, bus.seg_x[0]};
        head_y = {1'b0, bus.seg_y[0]};
        case (bus.dir)
            RIGHT:   head_x = head_x + 9'd1;
            DOWN:    head_y = head_y - 9'd1;
            LEFT:    head_x = head_x - 9'd1;
            UP:      head_y = head_y + 9'd1;
            default: head_x = head_x;
        endcase
    end

    assign bus.next_x = head_x[7:0];
    assign bus.next_y = head_y[7:0];

    // Catches both the wrap below 0 and the far edge
    assign bus.hit_wall = (head_x >= GRID_W_L) || (head_y >= GRID_H_L);

    // Food only counts on a cell that is on the board
    assign bus.ate = (head_x == {1'b0, food_x}) && (head_y == {1'b0, food_y})
                  && ({1'b0, food_x} < GRID_W_L) && ({1'b0, food_y} < GRID_H_L);

    // The tail vacates its cell unless this move makes the snake longer
    assign tail_leaves = !(bus.ate && (bus.length < MAX_LEN_L));

    always_comb begin
        bus.hit_self = 1'b0;
        for (int i = 0; i < MAX_LEN; i++) begin
            if ((LEN_W'(i) < bus.length)
                && ({1'b0, bus.seg_x[i]} == head_x)
                && ({1'b0, bus.seg_y[i]} == head_y)
                && !(tail_leaves && (LEN_W'(i) == bus.length - 1'b1))) begin
                bus.hit_self = 1'b1;
            end
        end
    end

    // A move can not both leave the board and find food
    always_comb begin
        a_wall_not_food: assert (!(bus.hit_wall && bus.ate))
            else $error("snake_collide: wall and food hit on the same move");
    end

endmodule

`default_nettype wire

//--- snake_body.sv
`timescale 1ns/10ps
`default_nettype none

module snake_body #(
    parameter int MAX_LEN = 8
) (
    input  logic    clk,
    input  logic    rst,
    snake_if.body   bus
);
    import snake_pkg::*;

    localparam int               LEN_W     = $clog2(MAX_LEN + 1);
    localparam logic [LEN_W-1:0] MAX_LEN_L = LEN_W'(MAX_LEN);

    coord_t           seg_x_q [MAX_LEN];
    coord_t           seg_y_q [MAX_LEN];
    logic [LEN_W-1:0] len_q;
    logic [LEN_W-1:0] len_next;

    // Grow only while there is room; at full length the tail just moves on
    always_comb begin
        if (bus.grow && (len_q < MAX_LEN_L)) begin
            len_next = len_q + 1'b1;
        end else begin
            len_next = len_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Segment shift register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || bus.restart) begin
            len_q <= LEN_W'(1);
            for (int i = 0; i < MAX_LEN; i++) begin
                seg_x_q[i] <= '0;
                seg_y_q[i] <= '0;
            end
            seg_x_q[0] <= START_X;
            seg_y_q[0] <= START_Y;
        end else if (bus.step) begin
            len_q      <= len_next;
            seg_x_q[0] <= bus.next_x;
            seg_y_q[0] <= bus.next_y;
            // Each segment follows the one ahead of it
            for (int i = 1; i < MAX_LEN; i++) begin
                if (LEN_W'(i) < len_next) begin
                    seg_x_q[i] <= seg_x_q[i-1];
                    seg_y_q[i] <= seg_y_q[i-1];
                end else begin
                    // Segments past the tail stay cleared
                    seg_x_q[i] <= '0;
                    seg_y_q[i] <= '0;
                end
            end
        end
    end

    assign bus.seg_x  = seg_x_q;
    assign bus.seg_y  = seg_y_q;
    assign bus.length = len_q;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Length in range
    a_len_range: assert property (
        @(posedge clk) disable iff (rst)
        (len_q >= LEN_W'(1)) && (len_q <= MAX_LEN_L)
    ) else $error("snake_body: length %0d out of range", len_q);

endmodule

`default_nettype wire

//--- snake_if.sv
`timescale 1ns/10ps
`default_nettype none

interface snake_if #(
    parameter int MAX_LEN = 8
);
    import snake_pkg::*;

    localparam int LEN_W = $clog2(MAX_LEN + 1);

    // Move commands from the controller
    logic             restart;
    logic             step;
    logic             grow;
    dir_t             dir;

    // Body state, segment 0 is the head
    coord_t           seg_x [MAX_LEN];
    coord_t           seg_y [MAX_LEN];
    logic [LEN_W-1:0] length;

    // Candidate next head and what it runs into
    coord_t           next_x;
    coord_t           next_y;
    logic             hit_wall;
    logic             hit_self;
    logic             ate;

    modport ctrl (
        output restart, step, grow, dir,
        input  hit_wall, hit_self, ate, length, seg_x, seg_y
    );

    modport body (
        input  restart, step, grow, next_x, next_y,
        output seg_x, seg_y, length
    );

    modport collide (
        input  seg_x, seg_y, length, dir,
        output next_x, next_y, hit_wall, hit_self, ate
    );

endinterface

`default_nettype wire

//--- snake_pkg.sv
`default_nettype none

package snake_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Board coordinates and motion
    ////////////////////////////////////////////////////////////////////////////

    // One grid cell index, x or y
    typedef logic [7:0] coord_t;

    // Move direction, x grows to the right and y grows upward
    typedef enum logic [1:0] {
        RIGHT = 2'd0,
        DOWN  = 2'd1,
        LEFT  = 2'd2,
        UP    = 2'd3
    } dir_t;

    // Game FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DEAD = 2'd2
    } game_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // APB register map, word index from PADDR[4:2]
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_DIR    = 3'd1,
        REG_FOOD   = 3'd2,
        REG_STATUS = 3'd3,
        REG_SCORE  = 3'd4,
        REG_HEAD   = 3'd5
    } reg_addr_t;

    // CTRL command bits
    localparam int CTRL_RESTART_BIT = 0;
    localparam int CTRL_STEP_BIT    = 1;

    // Head cell after a restart
    localparam coord_t START_X = 8'd4;
    localparam coord_t START_Y = 8'd4;

endpackage

`default_nettype wire
